// File: Bender.yml
package:
  name: spi_stream

sources:
  # Design, in compile order
  - files:
      - design/spi_stream_pkg.sv
      - design/sck_divider.sv
      - design/word_fifo.sv
      - design/spi_master.sv
      - design/spi_stream.sv

  # Testbench
  - target: test
    files:
      - tb/spi_stream_asserts.sv
      - tb/spi_stream_tb.sv

// File: design/sck_divider.sv
`timescale 1ns/1ps

module sck_divider import spi_stream_pkg::*; (
	input  logic CLK50MHZ,
	input  logic RST,
	// Held high by the engine for the whole transfer
	input  logic run,
	output logic sck_level,
	output logic tick
);

	div_cnt_t cnt;
	logic     started;
	logic     terminal;

	// Last cycle of a half period
	assign terminal = (cnt == DIV_LAST);

	////////////////////
	// Half period counter
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST || !run) begin
			cnt <= '0;
		end else if (terminal) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// First terminal count only marks the start of the frame
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !run) begin
			started <= 1'b0;
		end else if (terminal) begin
			started <= 1'b1;
		end
	end

	////////////////////
	// SCK level and tick
	////////////////////

	// Level stays low for the first half period, so the first bit
	// gets a full half period of setup before the first rising edge
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !run) begin
			sck_level <= 1'b0;
		end else if (terminal && started) begin
			sck_level <= ~sck_level;
		end
	end

	// Pulse at the start and on every high to low toggle
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !run) begin
			tick <= 1'b0;
		end else if (terminal) begin
			tick <= !started || sck_level;
		end else begin
			tick <= 1'b0;
		end
	end

endmodule

// File: design/spi_master.sv
`timescale 1ns/1ps

module spi_master import spi_stream_pkg::*; (
	input  logic      CLK50MHZ,
	input  logic      RST,
	// Transmit queue
	input  spi_word_t head_data,
	input  logic      empty,
	output logic      pop,
	// SCK divider
	output logic      run,
	input  logic      sck_level,
	input  logic      tick,
	// SPI pins
	output logic      spi_sck,
	output logic      spi_cs,
	output logic      spi_mosi,
	input  logic      spi_miso,
	// Received word
	output spi_word_t rx_data,
	output logic      rx_valid
);

	spi_state_e state;
	spi_state_e state_next;
	spi_word_t  shreg;
	bit_idx_t   bit_idx;
	logic       load;
	logic       shift_tick;
	logic       last_tick;

	// Take the head word as soon as one is waiting
	assign load = (state == IDLE) && !empty;
	assign pop  = load;

	// Divider runs only while shifting
	assign run = (state == SHIFT);

	assign shift_tick = (state == SHIFT) && tick;

	// Tick after the last bit closes the frame
	assign last_tick = shift_tick && (bit_idx == IDX_LAST);

	////////////////////
	// State machine
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			IDLE:
				if (!empty) begin
					state_next = SHIFT;
				end
			SHIFT:
				if (last_tick) begin
					state_next = DONE;
				end
			DONE:
				state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	////////////////////
	// Shift register and bit counter
	////////////////////

	// MSB leaves on MOSI, MISO enters at the bottom.
	// The first tick shifts in a dummy bit that the last tick pushes out
	always_ff @(posedge CLK50MHZ) begin
		if (load) begin
			shreg <= head_data;
		end else if (shift_tick) begin
			shreg <= {shreg[WORD_W-2:0], spi_miso};
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			bit_idx <= '0;
		end else if (load) begin
			bit_idx <= '0;
		end else if (shift_tick && !last_tick) begin
			bit_idx <= bit_idx + 1'b1;
		end
	end

	////////////////////
	// SPI pins
	////////////////////

	// New bit on each tick, SCK is low at that point
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_mosi <= 1'b0;
		end else if (shift_tick) begin
			spi_mosi <= last_tick ? 1'b0 : shreg[WORD_W-1];
		end else if (state != SHIFT) begin
			spi_mosi <= 1'b0;
		end
	end

	// Low from the first tick, high again after the last bit
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_cs <= 1'b1;
		end else if (shift_tick) begin
			spi_cs <= last_tick;
		end else if (state != SHIFT) begin
			spi_cs <= 1'b1;
		end
	end

	// Idle low SCK outside the frame
	assign spi_sck = spi_cs ? 1'b0 : sck_level;

	////////////////////
	// Receive output
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (state == DONE) begin
			rx_data <= shreg;
		end
	end

	// One pulse per transfer, lined up with the new rx_data
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= (state == DONE);
		end
	end

endmodule

// File: design/spi_stream.sv
`timescale 1ns/1ps

module spi_stream import spi_stream_pkg::*; (
	input  logic      CLK50MHZ,
	input  logic      RST,
	// Host write side
	input  spi_word_t tx_data,
	input  logic      tx_write,
	output logic      tx_full,
	// Host read side
	output spi_word_t rx_data,
	output logic      rx_valid,
	// SPI pins
	output logic      spi_sck,
	output logic      spi_cs,
	output logic      spi_mosi,
	input  logic      spi_miso
);

	// Queue to engine
	spi_word_t head_data;
	logic      fifo_empty;
	logic      fifo_pop;

	// Engine to divider
	logic      run;
	logic      sck_level;
	logic      tick;

	////////////////////
	// Serial clock
	////////////////////

	sck_divider i_sck_divider (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.run       (run),
		.sck_level (sck_level),
		.tick      (tick)
	);

	////////////////////
	// Transmit queue
	////////////////////

	word_fifo i_word_fifo (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.push      (tx_write),
		.push_data (tx_data),
		.pop       (fifo_pop),
		.head_data (head_data),
		.empty     (fifo_empty),
		.full      (tx_full)
	);

	////////////////////
	// SPI engine
	////////////////////

	spi_master i_spi_master (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.head_data (head_data),
		.empty     (fifo_empty),
		.pop       (fifo_pop),
		.run       (run),
		.sck_level (sck_level),
		.tick      (tick),
		.spi_sck   (spi_sck),
		.spi_cs    (spi_cs),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid)
	);

endmodule

// File: design/spi_stream_pkg.sv
package spi_stream_pkg;

	////////////////////
	// Sizes
	////////////////////

	// Bits per SPI transfer
	localparam int WORD_W = 32;

	// System clock cycles per SCK half period
	localparam int SCK_DIV = 6;

	// Transmit queue entries
	localparam int FIFO_DEPTH = 8;

	// Derived widths
	localparam int IDX_W   = $clog2(WORD_W + 1);
	localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);
	localparam int DIV_W   = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;

	////////////////////
	// Types
	////////////////////

	// Transmit and receive word
	typedef logic [WORD_W-1:0]  spi_word_t;

	// Engine bit counter, 0 to WORD_W
	typedef logic [IDX_W-1:0]   bit_idx_t;

	// Queue pointer and fill level
	typedef logic [PTR_W-1:0]   fifo_ptr_t;
	typedef logic [LEVEL_W-1:0] fifo_level_t;

	// SCK divider counter
	typedef logic [DIV_W-1:0]   div_cnt_t;

	// Engine states
	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		DONE
	} spi_state_e;

	////////////////////
	// Terminal values
	////////////////////

	localparam div_cnt_t    DIV_LAST   = div_cnt_t'(SCK_DIV - 1);
	localparam fifo_ptr_t   PTR_LAST   = fifo_ptr_t'(FIFO_DEPTH - 1);
	localparam fifo_level_t LEVEL_FULL = fifo_level_t'(FIFO_DEPTH);
	localparam bit_idx_t    IDX_LAST   = bit_idx_t'(WORD_W);

endpackage

// File: design/word_fifo.sv
`timescale 1ns/1ps

module word_fifo import spi_stream_pkg::*; (
	input  logic      CLK50MHZ,
	input  logic      RST,
	// Write side
	input  logic      push,
	input  spi_word_t push_data,
	// Read side, head shown ahead of the pop
	input  logic      pop,
	output spi_word_t head_data,
	// Status
	output logic      empty,
	output logic      full
);

	spi_word_t   mem [FIFO_DEPTH];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_level_t level;
	logic        do_push;
	logic        do_pop;

	// Pointer advance with wrap at the last entry
	function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
		fifo_ptr_t nxt;
		if (ptr == PTR_LAST) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	////////////////////
	// Status
	////////////////////

	assign empty = (level == '0);
	assign full  = (level == LEVEL_FULL);

	// Writes into a full queue are lost
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Oldest word, valid whenever empty is low
	assign head_data = mem[rd_ptr];

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	////////////////////
	// Pointers and level
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			wr_ptr <= '0;
		end else if (do_push) begin
			wr_ptr <= next_ptr(wr_ptr);
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			rd_ptr <= '0;
		end else if (do_pop) begin
			rd_ptr <= next_ptr(rd_ptr);
		end
	end

	// Push and pop together leave the level alone
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			level <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

// File: spi_stream.f
design/spi_stream_pkg.sv
design/sck_divider.sv
design/word_fifo.sv
design/spi_master.sv
design/spi_stream.sv
tb/spi_stream_asserts.sv
tb/spi_stream_tb.sv

// File: tb/spi_stream_asserts.sv
`timescale 1ns/1ps

module spi_stream_asserts import spi_stream_pkg::*; (
	input logic       CLK50MHZ,
	input logic       RST,
	input logic       spi_cs,
	input logic       spi_sck,
	input logic       spi_mosi,
	input logic       rx_valid,
	input logic       pop,
	input logic       empty,
	input spi_state_e state,
	input bit_idx_t   bit_idx
);

	// Read by the testbench at the end of the run
	int fail_count = 0;

	// Idle low SCK outside the frame
	sck_idle: assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_cs |-> !spi_sck)
		else begin
			fail_count++;
			$error("SCK high while CS is high");
		end

	// Slave samples on the rising edge, so the bit holds through the high phase
	mosi_hold: assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_sck |-> $stable(spi_mosi))
		else begin
			fail_count++;
			$error("MOSI changed while SCK was high");
		end

	rx_single: assert property (@(posedge CLK50MHZ) disable iff (RST)
		rx_valid |=> !rx_valid)
		else begin
			fail_count++;
			$error("rx_valid high for two cycles in a row");
		end

	pop_safe: assert property (@(posedge CLK50MHZ) disable iff (RST)
		pop |-> !empty)
		else begin
			fail_count++;
			$error("Pop from an empty queue");
		end

	// Frame only in SHIFT, counter never past the last bit
	frame_state: assert property (@(posedge CLK50MHZ) disable iff (RST)
		!spi_cs |-> (state == SHIFT && bit_idx <= IDX_LAST))
		else begin
			fail_count++;
			$error("CS low outside SHIFT or bit counter out of range");
		end

endmodule

bind spi_master spi_stream_asserts i_asserts (
	.CLK50MHZ (CLK50MHZ),
	.RST      (RST),
	.spi_cs   (spi_cs),
	.spi_sck  (spi_sck),
	.spi_mosi (spi_mosi),
	.rx_valid (rx_valid),
	.pop      (pop),
	.empty    (empty),
	.state    (state),
	.bit_idx  (bit_idx)
);

// File: tb/spi_stream_tb.sv
`timescale 1ns/1ps

module spi_stream_tb import spi_stream_pkg::*; ();

	logic      CLK50MHZ = 1'b0;
	logic      RST;
	spi_word_t tx_data;
	logic      tx_write;
	logic      tx_full;
	spi_word_t rx_data;
	logic      rx_valid;
	logic      spi_sck;
	logic      spi_cs;
	logic      spi_mosi;
	logic      spi_miso;

	integer    seed = 32'h9061;
	int        error_count = 0;
	int        mismatch_count = 0;
	int        n_accepted = 0;
	int        n_dropped = 0;
	int        n_frames = 0;
	int        n_rx = 0;
	logic      full_seen = 1'b0;

	// Scoreboard queues
	spi_word_t exp_tx [$];
	spi_word_t exp_rx [$];

	// Slave state
	logic      in_frame = 1'b0;
	int        edge_cnt;
	spi_word_t captured;
	spi_word_t reply;

	spi_stream i_dut (.*);

	always #10 CLK50MHZ = ~CLK50MHZ;

	////////////////////
	// Checks and reporting
	////////////////////

	task automatic check_word(input spi_word_t got, input spi_word_t exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input bit_idx_t got, input bit_idx_t exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic finish_run();
		int total;
		total = error_count + i_dut.i_spi_master.i_asserts.fail_count;
		$display("Errors: %0d, mismatches: %0d", total, mismatch_count);
		if (total == 0 && mismatch_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	////////////////////
	// Host side
	////////////////////

	task automatic step();
		@(posedge CLK50MHZ);
		#1;
	endtask

	// A write while full is lost in the DUT, so the model drops it too
	task automatic host_write(input spi_word_t data);
		tx_data  = data;
		tx_write = 1'b1;
		if (!tx_full) begin
			exp_tx.push_back(data);
			n_accepted++;
		end else begin
			n_dropped++;
		end
		step();
		tx_write = 1'b0;
	endtask

	task automatic wait_cs_low(input int limit, output bit ok);
		int n;
		n = 0;
		while (spi_cs !== 1'b0 && n < limit) begin
			step();
			n++;
		end
		ok = (spi_cs === 1'b0);
		if (!ok) begin
			report_error("timeout waiting for CS to go low");
		end
	endtask

	task automatic wait_drained(input int limit, output bit ok);
		int n;
		n = 0;
		while ((exp_tx.size() != 0 || exp_rx.size() != 0) && n < limit) begin
			step();
			n++;
		end
		ok = (exp_tx.size() == 0 && exp_rx.size() == 0);
		if (!ok) begin
			report_error("timeout waiting for all queued words to be sent and received");
		end
	endtask

	////////////////////
	// SPI slave model
	////////////////////

	always @(negedge spi_cs) begin
		in_frame = 1'b1;
		edge_cnt = 0;
		captured = '0;
		reply    = $random(seed);
		#1 spi_miso = reply[WORD_W-1];
	end

	// Master samples at the falling edge after rising edge k, so bit k goes out after edge k
	always @(posedge spi_sck) begin
		if (in_frame) begin
			captured = {captured[WORD_W-2:0], spi_mosi};
			edge_cnt++;
			#1;
			if (edge_cnt <= WORD_W) begin
				spi_miso = reply[WORD_W-edge_cnt];
			end
		end
	end

	always @(posedge spi_cs) begin
		bit_idx_t edges;
		if (in_frame) begin
			in_frame = 1'b0;
			n_frames++;
			edges = (edge_cnt > WORD_W) ? bit_idx_t'(WORD_W + 1) : bit_idx_t'(edge_cnt);
			check_count(edges, bit_idx_t'(WORD_W), "SCK rising edges in frame");
			if (exp_tx.size() == 0) begin
				report_error("transfer started with no accepted host word");
			end else begin
				check_word(captured, exp_tx.pop_front(), "word captured from MOSI");
			end
			exp_rx.push_back(reply);
		end
	end

	////////////////////
	// Output monitor
	////////////////////

	always @(negedge CLK50MHZ) begin
		if (RST === 1'b0) begin
			if (spi_cs === 1'b1 && spi_sck !== 1'b0) begin
				report_error("SCK is not low while CS is high");
			end
			if (tx_full === 1'b1) begin
				full_seen = 1'b1;
			end
			if (rx_valid === 1'b1) begin
				n_rx++;
				if (exp_rx.size() == 0) begin
					report_error("rx_valid without a completed transfer");
				end else begin
					check_word(rx_data, exp_rx.pop_front(), "rx_data");
				end
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int gap;
		int drain_limit;
		bit ok;
		RST      = 1'b1;
		tx_data  = '0;
		tx_write = 1'b0;
		spi_miso = 1'b0;
		drain_limit = (FIFO_DEPTH + 2) * ((WORD_W + 1) * 2 * SCK_DIV + 4);
		repeat (2) @(posedge CLK50MHZ);
		#1 RST = 1'b0;

		// Quiet bus with no writes
		repeat (500) begin
			step();
			if (spi_cs !== 1'b1 || spi_sck !== 1'b0 || spi_mosi !== 1'b0 ||
				rx_valid !== 1'b0 || tx_full !== 1'b0) begin
				report_error("outputs left their reset state with no writes");
			end
		end

		// Fill the queue behind a running transfer
		full_seen = 1'b0;
		host_write($random(seed));
		wait_cs_low(4 * SCK_DIV, ok);
		if (ok) begin
			n_dropped = 0;
			repeat (FIFO_DEPTH + 1) host_write($random(seed));
			if (!full_seen) begin
				report_error("tx_full did not rise during the back to back burst");
			end
			if (n_dropped != 1) begin
				report_error($sformatf("%0d writes dropped in the burst instead of one",
					n_dropped));
			end
			wait_drained(drain_limit, ok);
		end

		// Random stream
		if (ok) begin
			for (int i = 0; i < 200; i++) begin
				host_write($random(seed));
				gap = $random(seed) & 32'h3ff;
				repeat (gap) step();
			end
			wait_drained(drain_limit, ok);
		end

		if (ok) begin
			repeat (10) step();
			if (n_rx != n_frames) begin
				report_error($sformatf("%0d transfers but %0d rx_valid pulses",
					n_frames, n_rx));
			end
			if (n_frames != n_accepted) begin
				report_error($sformatf("%0d words accepted but %0d transfers",
					n_accepted, n_frames));
			end
		end
		finish_run();
	end

endmodule
